// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } branch_t;

    typedef enum logic [1:0] {
        mem_word, mem_byte_signed, mem_byte_unsigned
    } mem_size_t;

    // op / op_imm
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    // branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    // loads, stores, jalr
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_JALR   = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_instr_u;

    localparam logic [31:0] INSTR_NOP = 32'h0000_0013; // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    localparam int XLEN        = 32;
    localparam int REG_COUNT   = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = 8;   // word index, byte offset excluded

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;

    typedef enum logic [1:0] {
        wb_alu, wb_mem, wb_pc4
    } wb_sel_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      a_sel_pc;   // a = pc instead of rs1
        logic      b_sel_imm;  // b = imm instead of rs2
        branch_t   branch;
        logic      jump;
        logic      jump_reg;   // jalr base is rs1
        logic      mem_read;
        logic      mem_write;
        mem_size_t mem_size;
        logic      reg_write;
        wb_sel_t   wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

// ==== decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder import isa_pkg::*, core_pkg::*; (
    input  rv_instr_u instr,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm,
    output ctrl_t     ctrl
);

    opcode_t    opcode;
    logic [2:0] f3;
    logic [6:0] f7;

    function automatic alu_op_t arith_op(input logic [2:0] funct3, input logic alt);
        alu_op_t op;
        op = alu_add;
        case (funct3)
            F3_ADD_SUB: op = alt ? alu_sub : alu_add;
            F3_SLL:     op = alu_sll;
            F3_SLT:     op = alu_slt;
            F3_SLTU:    op = alu_sltu;
            F3_XOR:     op = alu_xor;
            F3_SRL_SRA: op = alt ? alu_sra : alu_srl;
            F3_OR:      op = alu_or;
            F3_AND:     op = alu_and;
            default:    op = alu_add;
        endcase
        return op;
    endfunction

    // register fields sit in the same place in every format
    assign opcode = instr.r.opcode;
    assign f3     = instr.r.funct3;
    assign f7     = instr.r.funct7;
    assign rs1    = instr.r.rs1;
    assign rs2    = instr.r.rs2;
    assign rd     = instr.r.rd;

    always_comb begin
        case (opcode)
            opc_op_imm, opc_load, opc_jalr:
                imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            opc_store:
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            opc_branch:
                imm = {{20{instr.b.imm_12}}, instr.b.imm_11, instr.b.imm_10_5,
                       instr.b.imm_4_1, 1'b0};
            opc_lui, opc_auipc:
                imm = {instr.u.imm, 12'b0};
            opc_jal:
                imm = {{12{instr.j.imm_20}}, instr.j.imm_19_12, instr.j.imm_11,
                       instr.j.imm_10_1, 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            opc_op: begin
                if (f7 == F7_BASE || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA))) begin
                    ctrl.alu_op    = arith_op(f3, f7[5]);
                    ctrl.reg_write = 1'b1;
                end
            end
            opc_op_imm: begin
                // shift immediates carry funct7 in imm[11:5]
                if ((f3 != F3_SLL && f3 != F3_SRL_SRA) || f7 == F7_BASE ||
                    (f7 == F7_ALT && f3 == F3_SRL_SRA)) begin
                    ctrl.alu_op    = arith_op(f3, f3 == F3_SRL_SRA && f7 == F7_ALT);
                    ctrl.b_sel_imm = 1'b1;
                    ctrl.reg_write = 1'b1;
                end
            end
            opc_load: begin
                if (f3 == F3_WORD || f3 == F3_BYTE || f3 == F3_BYTE_U) begin
                    ctrl.b_sel_imm = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_mem;
                    ctrl.mem_size  = (f3 == F3_WORD) ? mem_word :
                                     (f3 == F3_BYTE) ? mem_byte_signed : mem_byte_unsigned;
                end
            end
            opc_store: begin
                if (f3 == F3_WORD || f3 == F3_BYTE) begin
                    ctrl.b_sel_imm = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.mem_size  = (f3 == F3_WORD) ? mem_word : mem_byte_signed;
                end
            end
            opc_branch: begin
                case (f3)
                    F3_BEQ:  ctrl.branch = br_beq;
                    F3_BNE:  ctrl.branch = br_bne;
                    F3_BLT:  ctrl.branch = br_blt;
                    F3_BGE:  ctrl.branch = br_bge;
                    F3_BLTU: ctrl.branch = br_bltu;
                    F3_BGEU: ctrl.branch = br_bgeu;
                    default: ctrl.branch = br_none;
                endcase
            end
            opc_lui: begin
                ctrl.alu_op    = alu_pass_b;
                ctrl.b_sel_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            opc_auipc: begin
                ctrl.a_sel_pc  = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            opc_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = wb_pc4;
            end
            opc_jalr: begin
                if (f3 == F3_JALR) begin
                    ctrl.jump      = 1'b1;
                    ctrl.jump_reg  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_pc4;
                end
            end
            default: ctrl = '0; // unknown opcode, nop
        endcase
        ctrl.reg_write = ctrl.reg_write && (rd != '0); // x0 writes never retire
    end

    // a load and a store must never come from the same word
    mem_excl_a: assert final ($isunknown(instr) || !(ctrl.mem_read && ctrl.mem_write))
        else $error("decoder set mem_read and mem_write together");

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import isa_pkg::*, core_pkg::*; (
    input  ctrl_t ctrl,
    input  word_t pc,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t imm,
    output word_t result
);

    word_t      a;
    word_t      b;
    logic [4:0] shamt;

    assign a     = ctrl.a_sel_pc ? pc : rs1_data;
    assign b     = ctrl.b_sel_imm ? imm : rs2_data;
    assign shamt = b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   result = {{(XLEN-1){1'b0}}, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b; // lui
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_unit import isa_pkg::*, core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  ctrl_t ctrl,
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  word_t imm,
    output word_t pc,
    output word_t pc_plus4
);

    word_t pc_next;
    word_t target;
    logic  taken;

    always_comb begin
        case (ctrl.branch)
            br_beq:  taken = (rs1_data == rs2_data);
            br_bne:  taken = (rs1_data != rs2_data);
            br_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            br_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            br_bltu: taken = (rs1_data < rs2_data);
            br_bgeu: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + word_t'(4);

    // jalr clears bit 0 of the sum
    assign target  = ctrl.jump_reg ? ((rs1_data + imm) & ~word_t'(1)) : (pc + imm);
    assign pc_next = (ctrl.jump || taken) ? target : pc_plus4;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    pc_align_a: assert property (@(posedge clk) disable iff (!reset) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

`default_nettype wire

// ==== register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      we,
    input  word_t     wdata,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t [REG_COUNT-1:0] regs;

    // reads see the value from before this cycle's write
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            regs <= '0;
        end else if (we) begin
            regs[rd] <= wdata; // we is already low for rd == 0
        end
    end

    x0_zero_a: assert property (@(posedge clk) disable iff (!reset) regs[0] == '0)
        else $error("x0 storage became %h", regs[0]);

endmodule

`default_nettype wire

// ==== data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_memory import isa_pkg::*, core_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  ctrl_t ctrl,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata
);

    word_t mem [DMEM_WORDS];

    logic [DMEM_ADDR_W-1:0] index;
    logic [1:0]             lane;
    word_t                  word;
    logic [7:0]             byte_val;

    assign index    = addr[DMEM_ADDR_W+1:2]; // upper address bits ignored
    assign lane     = addr[1:0];
    assign word     = mem[index];
    assign byte_val = word[{lane, 3'b000} +: 8];

    always_comb begin
        if (!ctrl.mem_read) begin
            rdata = '0;
        end else begin
            case (ctrl.mem_size)
                mem_byte_signed:   rdata = {{(XLEN-8){byte_val[7]}}, byte_val};
                mem_byte_unsigned: rdata = {{(XLEN-8){1'b0}}, byte_val};
                default:           rdata = word;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset && ctrl.mem_write) begin
            if (ctrl.mem_size == mem_word) begin
                mem[index] <= wdata;
            end else begin
                mem[index][{lane, 3'b000} +: 8] <= wdata[7:0]; // sb, one lane only
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core import isa_pkg::*, core_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  rv_instr_u instr,
    output word_t     pc,
    output retire_t   retire
);

    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    word_t     mem_rdata;
    word_t     pc_plus4;
    word_t     wb_data;

    decoder decoder_i (
        .instr (instr),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm),
        .ctrl  (ctrl)
    );

    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (ctrl.reg_write),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu alu_i (
        .ctrl     (ctrl),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .result   (alu_result)
    );

    pc_unit pc_unit_i (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    data_memory data_memory_i (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl),
        .addr  (alu_result),
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    // writeback select
    always_comb begin
        case (ctrl.wb_sel)
            wb_mem:  wb_data = mem_rdata;
            wb_pc4:  wb_data = pc_plus4; // jal, jalr link
            default: wb_data = alu_result;
        endcase
    end

    assign retire = '{we: ctrl.reg_write, rd: rd, data: wb_data};

endmodule

`default_nettype wire

// ==== rv_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import isa_pkg::*, core_pkg::*;;

    localparam int MAX_TESTS    = 128;
    localparam int RESET_CYCLES = 16;

    logic      clk;
    logic      reset;
    rv_instr_u instr;
    word_t     pc;
    retire_t   retire;

    // trace columns
    logic [31:0] t_instr [MAX_TESTS];
    word_t       t_pc    [MAX_TESTS];
    logic        t_we    [MAX_TESTS];
    reg_addr_t   t_rd    [MAX_TESTS];
    word_t       t_data  [MAX_TESTS];

    int num_tests = 0;
    int errors    = 0;
    int checks    = 0;
    int cycles    = 0;
    int limit     = RESET_CYCLES + MAX_TESTS + 20;

    rv_core dut_i (
        .clk    (clk),
        .reset  (reset),
        .instr  (instr),
        .pc     (pc),
        .retire (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w;
        logic [31:0] p;
        logic [31:0] d;
        int          we_v;
        int          rd_v;
        fd = $fopen("rv_core_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file rv_core_tests.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && num_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %d %d %h", w, p, we_v, rd_v, d);
            if (n == 5) begin
                t_instr[num_tests] = w;
                t_pc[num_tests]    = p;
                t_we[num_tests]    = (we_v != 0);
                t_rd[num_tests]    = rd_v[4:0];
                t_data[num_tests]  = d;
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // rd and data only mean something when a write retires
    task automatic check_step(input int i);
        checks++;
        if (pc !== t_pc[i]) begin
            $display("Error at %0d ns: pc expected %h, got %h (line %0d)",
                     $time, t_pc[i], pc, i);
            errors++;
        end
        if (retire.we !== t_we[i]) begin
            $display("Error at %0d ns: retire.we expected %b, got %b (line %0d)",
                     $time, t_we[i], retire.we, i);
            errors++;
        end
        if (t_we[i]) begin
            if (retire.rd !== t_rd[i]) begin
                $display("Error at %0d ns: retire.rd expected %0d, got %0d (line %0d)",
                         $time, t_rd[i], retire.rd, i);
                errors++;
            end
            if (retire.data !== t_data[i]) begin
                $display("Error at %0d ns: retire.data expected %h, got %h (line %0d)",
                         $time, t_data[i], retire.data, i);
                errors++;
            end
        end
    endtask

    initial begin
        reset = 1'b0;
        instr = INSTR_NOP;
        load_tests();
        if (num_tests == 0) begin
            $display("No instruction lines were read from rv_core_tests.txt");
            errors++;
        end
        limit = RESET_CYCLES + num_tests + 20;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (pc !== RESET_PC) begin
                $display("Error at %0d ns: pc during reset expected %h, got %h",
                         $time, RESET_PC, pc);
                errors++;
            end
            if (retire.we !== 1'b0) begin
                $display("Error at %0d ns: retire.we during reset expected 0, got %b",
                         $time, retire.we);
                errors++;
            end
            @(posedge clk);
        end

        // release reset on the same edge as the first instruction, so pc starts at 0
        reset <= 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            instr <= t_instr[i];
            @(negedge clk);
            check_step(i);
            @(posedge clk);
        end

        $display("%0d steps checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog
    initial begin
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles, %0d errors so far",
                 limit, errors);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core_tests.txt ====
# columns: instr_word expected_pc retire_we retire_rd(decimal) retire_data
# one line per executed instruction; rd and data are ignored when we is 0
ffb00093 00000000 1 1  fffffffb
00300113 00000004 1 2  00000003
002081b3 00000008 1 3  fffffffe
40110233 0000000c 1 4  00000008
0020a2b3 00000010 1 5  00000001
0020b333 00000014 1 6  00000000
0020c3b3 00000018 1 7  fffffff8
4020d433 0000001c 1 8  ffffffff
0020d4b3 00000020 1 9  1fffffff
00211533 00000024 1 10 00000018
0020e5b3 00000028 1 11 fffffffb
0020f633 0000002c 1 12 00000003
0f00f693 00000030 1 13 000000f0
ffc0a713 00000034 1 14 00000001
4010d793 00000038 1 15 fffffffd
12345837 0000003c 1 16 12345000
00001897 00000040 1 17 00001040
00700013 00000044 0 0  00000000
04000913 00000048 1 18 00000040
01092223 0000004c 0 0  00000000
00492983 00000050 1 19 12345000
09c00a13 00000054 1 20 0000009c
01490323 00000058 0 0  00000000
00690a83 0000005c 1 21 ffffff9c
00694b03 00000060 1 22 0000009c
00492b83 00000064 1 23 129c5000
00208463 00000068 0 0  00000000
00210463 0000006c 0 0  00000000
00211463 00000074 0 0  00000000
00209463 00000078 0 0  00000000
0020c463 00000080 0 0  00000000
00114463 00000088 0 0  00000000
00115463 0000008c 0 0  00000000
0020d463 00000094 0 0  00000000
0020e463 00000098 0 0  00000000
00116463 0000009c 0 0  00000000
00117463 000000a4 0 0  00000000
0020f463 000000a8 0 0  00000000
00c00c6f 000000b0 1 24 000000b4
09190ce7 000000bc 1 25 000000c0
0000007f 000000d0 0 0  00000000
ff9ffd6f 000000d4 1 26 000000d8
001d0d93 000000cc 1 27 000000d9

// ==== compile.f ====
isa_pkg.sv
core_pkg.sv
decoder.sv
alu.sv
pc_unit.sv
register_file.sv
data_memory.sv
rv_core.sv
rv_core_tb.sv
